// File: filelist.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/reg_inuse.sv
rtl/reg_file.sv
rtl/issue_ctrl.sv
rtl/exec_units.sv
rtl/issue_core.sv
verif/tb_clock.sv
verif/tb_issue_core.sv

// File: rtl/exec_units.sv
// execution units
// single-cycle alu, pipelined multiplier (low word)
// and the writeback merge
`timescale 1ns/1ps
`default_nettype none

`include "issue_defs.svh"

module exec_units (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     issue_valid,
    input  wire pipe_pkg::unit_e          issue_unit,
    input  wire isa_pkg::op_e             issue_op,
    input  wire logic [`ISSUE_REG_AW-1:0] issue_rd,
    input  wire logic [`ISSUE_XLEN-1:0]   issue_imm,
    input  wire logic [`ISSUE_XLEN-1:0]   rs1_data,
    input  wire logic [`ISSUE_XLEN-1:0]   rs2_data,
    output logic                          mul_tail_busy,
    output logic                          wb_valid,
    output logic [`ISSUE_REG_AW-1:0]      wb_rd,
    output logic [`ISSUE_XLEN-1:0]        wb_data
);

    localparam int TAIL = `ISSUE_MUL_STAGES - 1;

    logic                         alu_valid;
    logic [`ISSUE_REG_AW-1:0]     alu_rd;
    logic [`ISSUE_XLEN-1:0]       alu_result;
    logic [`ISSUE_XLEN-1:0]       alu_next;

    logic [`ISSUE_MUL_STAGES-1:0] mul_valid;
    logic [`ISSUE_REG_AW-1:0]     mul_rd   [`ISSUE_MUL_STAGES];
    logic [`ISSUE_XLEN-1:0]       mul_prod [`ISSUE_MUL_STAGES];

    ////////////////////////////////////////
    // alu

    always_comb begin
        case (issue_op)
            isa_pkg::OP_SUB:  alu_next = rs1_data - rs2_data;
            isa_pkg::OP_XOR:  alu_next = rs1_data ^ rs2_data;
            isa_pkg::OP_ADDI: alu_next = rs1_data + issue_imm;
            default:          alu_next = rs1_data + rs2_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= issue_valid && (issue_unit == pipe_pkg::UNIT_ALU);
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        alu_rd     <= issue_rd;
        alu_result <= alu_next;
    end

    ////////////////////////////////////////
    // multiplier

    always_ff @(posedge clk) begin
        if (rst) begin
            mul_valid <= '0;
        end else begin
            mul_valid <= {mul_valid[TAIL-1:0], issue_valid && (issue_unit == pipe_pkg::UNIT_MUL)};
        end
    end

    // first stage forms the low word, later stages carry it
    always_ff @(posedge clk) begin
        mul_rd[0]   <= issue_rd;
        mul_prod[0] <= rs1_data * rs2_data;
        for (int i = 1; i < `ISSUE_MUL_STAGES; i++) begin
            mul_rd[i]   <= mul_rd[i-1];
            mul_prod[i] <= mul_prod[i-1];
        end
    end

    // stage feeding the tail, occupied tail on the next cycle
    assign mul_tail_busy = mul_valid[TAIL-1];

    ////////////////////////////////////////
    // writeback merge

    assign wb_valid = alu_valid || mul_valid[TAIL];
    assign wb_rd    = mul_valid[TAIL] ? mul_rd[TAIL]   : alu_rd;
    assign wb_data  = mul_valid[TAIL] ? mul_prod[TAIL] : alu_result;

    // relies on the issue side holding alu ops behind the mul tail
    a_one_wb: assert property (@(posedge clk) disable iff (rst)
        !(alu_valid && mul_valid[TAIL]))
        else $error("alu and multiplier writeback in the same cycle");

endmodule

`default_nettype wire

// File: rtl/isa_pkg.sv
// instruction set types for the issue block
// opcode enum of the register-to-register stream
`default_nettype none

`include "issue_defs.svh"

package isa_pkg;

    ////////////////////////////////////////
    // opcodes

    // all ops write rd
    // addi takes rs1 + imm and ignores rs2
    // mul keeps the low word of the product
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_XOR  = 3'd2,
        OP_ADDI = 3'd3,
        OP_MUL  = 3'd4
    } op_e;

endpackage

`default_nettype wire

// File: rtl/issue_core.sv
// issue block top level
// issue controller, register file and execution units
`timescale 1ns/1ps
`default_nettype none

`include "issue_defs.svh"

module issue_core (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     in_valid,
    input  wire isa_pkg::op_e             in_op,
    input  wire logic [`ISSUE_REG_AW-1:0] in_rd,
    input  wire logic [`ISSUE_REG_AW-1:0] in_rs1,
    input  wire logic [`ISSUE_REG_AW-1:0] in_rs2,
    input  wire logic [`ISSUE_XLEN-1:0]   in_imm,
    output logic                          in_ready,
    output logic                          wb_valid,
    output logic [`ISSUE_REG_AW-1:0]      wb_rd,
    output logic [`ISSUE_XLEN-1:0]        wb_data
);

    // issue side to the units
    logic                     issue_valid;
    pipe_pkg::unit_e          issue_unit;
    isa_pkg::op_e             issue_op;
    logic [`ISSUE_REG_AW-1:0] issue_rd;
    logic [`ISSUE_XLEN-1:0]   issue_imm;
    logic                     mul_tail_busy;

    // operands, read in the accept cycle
    logic [`ISSUE_XLEN-1:0]   rs1_data;
    logic [`ISSUE_XLEN-1:0]   rs2_data;

    issue_ctrl issue_ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_op         (in_op),
        .in_rd         (in_rd),
        .in_rs1        (in_rs1),
        .in_rs2        (in_rs2),
        .in_imm        (in_imm),
        .mul_tail_busy (mul_tail_busy),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .in_ready      (in_ready),
        .issue_valid   (issue_valid),
        .issue_unit    (issue_unit),
        .issue_op      (issue_op),
        .issue_rd      (issue_rd),
        .issue_imm     (issue_imm)
    );

    // writeback lands here, readable the cycle after
    reg_file reg_file_i (
        .clk      (clk),
        .rs1_addr (in_rs1),
        .rs2_addr (in_rs2),
        .we       (wb_valid),
        .waddr    (wb_rd),
        .wdata    (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    exec_units exec_units_i (
        .clk           (clk),
        .rst           (rst),
        .issue_valid   (issue_valid),
        .issue_unit    (issue_unit),
        .issue_op      (issue_op),
        .issue_rd      (issue_rd),
        .issue_imm     (issue_imm),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .mul_tail_busy (mul_tail_busy),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

endmodule

`default_nettype wire

// File: rtl/issue_ctrl.sv
// issue controller
// init sweep FSM, operand hazard check, accept decision, unit select
// owns the in-use scoreboard
`timescale 1ns/1ps
`default_nettype none

`include "issue_defs.svh"

module issue_ctrl (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     in_valid,
    input  wire isa_pkg::op_e             in_op,
    input  wire logic [`ISSUE_REG_AW-1:0] in_rd,
    input  wire logic [`ISSUE_REG_AW-1:0] in_rs1,
    input  wire logic [`ISSUE_REG_AW-1:0] in_rs2,
    input  wire logic [`ISSUE_XLEN-1:0]   in_imm,
    input  wire logic                     mul_tail_busy,
    input  wire logic                     wb_valid,
    input  wire logic [`ISSUE_REG_AW-1:0] wb_rd,
    output logic                          in_ready,
    output logic                          issue_valid,
    output pipe_pkg::unit_e               issue_unit,
    output isa_pkg::op_e                  issue_op,
    output logic [`ISSUE_REG_AW-1:0]      issue_rd,
    output logic [`ISSUE_XLEN-1:0]        issue_imm
);

    pipe_pkg::issue_state_e   state;
    logic [`ISSUE_REG_AW-1:0] init_cnt;
    logic                     clr;
    logic                     rs1_inuse;
    logic                     rs2_inuse;
    logic                     rd_inuse;
    logic                     data_hazard;
    logic                     wb_hazard;
    logic                     accept;
    logic                     retired;

    ////////////////////////////////////////
    // init FSM

    // one cycle per scoreboard entry over a power-of-two register count
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= pipe_pkg::ST_INIT;
            init_cnt <= '0;
        end else if (state == pipe_pkg::ST_INIT) begin
            init_cnt <= init_cnt + {{(`ISSUE_REG_AW-1){1'b0}}, 1'b1};
            if (&init_cnt) begin
                state <= pipe_pkg::ST_RUN;
            end
        end
    end

    assign clr = (state == pipe_pkg::ST_INIT);

    ////////////////////////////////////////
    // hazard check and accept

    // x0 is never tracked
    assign data_hazard = ((in_rs1 != '0) && rs1_inuse) ||
                         ((in_rs2 != '0) && rs2_inuse) ||
                         ((in_rd  != '0) && rd_inuse);

    // alu result would land on the same cycle as the mul tail
    assign wb_hazard = (in_op != isa_pkg::OP_MUL) && mul_tail_busy;

    assign in_ready = !clr && !data_hazard && !wb_hazard;
    assign accept   = in_valid && in_ready;

    // x0 writes are dropped here with nothing to track or execute
    assign issue_valid = accept && (in_rd != '0);
    assign issue_unit  = (in_op == isa_pkg::OP_MUL) ? pipe_pkg::UNIT_MUL : pipe_pkg::UNIT_ALU;
    assign issue_op    = in_op;
    assign issue_rd    = in_rd;
    assign issue_imm   = in_imm;

    assign retired = wb_valid && (wb_rd != '0);

    ////////////////////////////////////////
    // scoreboard

    reg_inuse reg_inuse_i (
        .clk             (clk),
        .rst             (rst),
        .clr             (clr),
        .rs1_addr        (in_rs1),
        .rs2_addr        (in_rs2),
        .issued_rd_addr  (in_rd),
        .retired_rd_addr (wb_rd),
        .issued          (issue_valid),
        .retired         (retired),
        .rs1_inuse       (rs1_inuse),
        .rs2_inuse       (rs2_inuse),
        .rd_inuse        (rd_inuse)
    );

    // an issue in init would retire while the sweep owns the retire port
    a_no_wb_init: assert property (@(posedge clk) disable iff (rst)
        (state == pipe_pkg::ST_INIT) |-> !wb_valid)
        else $error("writeback during scoreboard init");

endmodule

`default_nettype wire

// File: rtl/issue_defs.svh
// issue block sizing macros
// register count, register address width, data width
// and multiplier pipeline depth
`ifndef ISSUE_DEFS_SVH
`define ISSUE_DEFS_SVH

////////////////////////////////////////
// architectural register file

// number of integer registers, x0 included
`define ISSUE_NUM_REGS 32

// register address width, 2**ISSUE_REG_AW == ISSUE_NUM_REGS
`define ISSUE_REG_AW 5

// data path width
`define ISSUE_XLEN 32

////////////////////////////////////////
// execution units

// multiplier register stages, result leaves the last one
`define ISSUE_MUL_STAGES 3

`endif

// File: rtl/pipe_pkg.sv
// pipeline control types for the issue block
// issue controller state and execution unit select
`default_nettype none

`include "issue_defs.svh"

package pipe_pkg;

    ////////////////////////////////////////
    // issue controller FSM

    // init while the scoreboard sweep runs
    typedef enum logic {
        ST_INIT = 1'b0,
        ST_RUN  = 1'b1
    } issue_state_e;

    ////////////////////////////////////////
    // execution unit select

    // single-cycle alu or pipelined multiplier
    typedef enum logic {
        UNIT_ALU = 1'b0,
        UNIT_MUL = 1'b1
    } unit_e;

endpackage

`default_nettype wire

// File: rtl/reg_file.sv
// integer register file
// two combinational read ports, one synchronous write port
// x0 ignores writes and reads as zero
`timescale 1ns/1ps
`default_nettype none

`include "issue_defs.svh"

module reg_file (
    input  wire logic                     clk,
    input  wire logic [`ISSUE_REG_AW-1:0] rs1_addr,
    input  wire logic [`ISSUE_REG_AW-1:0] rs2_addr,
    input  wire logic                     we,
    input  wire logic [`ISSUE_REG_AW-1:0] waddr,
    input  wire logic [`ISSUE_XLEN-1:0]   wdata,
    output logic      [`ISSUE_XLEN-1:0]   rs1_data,
    output logic      [`ISSUE_XLEN-1:0]   rs2_data
);

    // storage, entry 0 never written
    logic [`ISSUE_XLEN-1:0] regs [`ISSUE_NUM_REGS];

    ////////////////////////////////////////
    // write port

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    ////////////////////////////////////////
    // read ports

    // x0 forced to zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// File: rtl/reg_inuse.sv
// register in-use scoreboard
// issue bank and retire bank, in use when the two bits differ
// clear sweep walks all entries after reset
`timescale 1ns/1ps
`default_nettype none

`include "issue_defs.svh"

module reg_inuse (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     clr,
    input  wire logic [`ISSUE_REG_AW-1:0] rs1_addr,
    input  wire logic [`ISSUE_REG_AW-1:0] rs2_addr,
    input  wire logic [`ISSUE_REG_AW-1:0] issued_rd_addr,
    input  wire logic [`ISSUE_REG_AW-1:0] retired_rd_addr,
    input  wire logic                     issued,
    input  wire logic                     retired,
    output logic                          rs1_inuse,
    output logic                          rs2_inuse,
    output logic                          rd_inuse
);

    // one bit per register in each bank
    logic bank_issue  [`ISSUE_NUM_REGS];
    logic bank_retire [`ISSUE_NUM_REGS];

    // sweep address while clr is held
    logic [`ISSUE_REG_AW-1:0] clr_addr;
    logic [`ISSUE_REG_AW-1:0] ret_addr;
    logic                     collision;
    logic                     retire_inuse;

    ////////////////////////////////////////
    // clear sweep

    always_ff @(posedge clk) begin
        if (rst) begin
            clr_addr <= '0;
        end else if (clr) begin
            clr_addr <= clr_addr + {{(`ISSUE_REG_AW-1){1'b0}}, 1'b1};
        end
    end

    // retire port shared with the sweep
    assign ret_addr = clr ? clr_addr : retired_rd_addr;

    ////////////////////////////////////////
    // bank writes

    // same register retiring this cycle
    assign collision = retired && (issued_rd_addr == retired_rd_addr);

    // issue makes the pair differ, against the retire bank's next value
    always_ff @(posedge clk) begin
        if (issued) begin
            bank_issue[issued_rd_addr] <= collision ? ~bank_issue[retired_rd_addr]
                                                    : ~bank_retire[issued_rd_addr];
        end
    end

    // retire or sweep makes the pair equal again
    always_ff @(posedge clk) begin
        if (retired || clr) begin
            bank_retire[ret_addr] <= bank_issue[ret_addr];
        end
    end

    ////////////////////////////////////////
    // lookups

    assign rs1_inuse    = bank_issue[rs1_addr] ^ bank_retire[rs1_addr];
    assign rs2_inuse    = bank_issue[rs2_addr] ^ bank_retire[rs2_addr];
    assign rd_inuse     = bank_issue[issued_rd_addr] ^ bank_retire[issued_rd_addr];
    assign retire_inuse = bank_issue[retired_rd_addr] ^ bank_retire[retired_rd_addr];

    ////////////////////////////////////////
    // assertions

    // writeback must match an earlier issue
    a_retire_inuse: assert property (@(posedge clk) disable iff (rst)
        (retired && !clr) |-> retire_inuse)
        else $error("retire of register %0d not in use", retired_rd_addr);

    // issue side must hold back on a pending rd
    a_issue_free: assert property (@(posedge clk) disable iff (rst)
        issued |-> !rd_inuse)
        else $error("issue of register %0d already in use", issued_rd_addr);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the issue core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_issue_core \
    -Mdir obj_dir -o sim_issue_core
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_issue_core)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qxF '** PASS **'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: verif/tb_clock.sv
// testbench clock and reset generator
// free-running clock, synchronous reset held for a few cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release just after an edge, like the other inputs
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: verif/tb_issue_core.sv
// testbench for the issue core
// random instruction stream over a small register pool
// in-order reference model with per-register pending results
// writeback value, timing and hazard checks, timeout and summary
`timescale 1ns/1ps
`default_nettype none

`include "issue_defs.svh"

module tb_issue_core;

    typedef logic [`ISSUE_REG_AW-1:0] reg_addr_t;
    typedef logic [`ISSUE_XLEN-1:0]   word_t;

    localparam int SEED           = 47016;
    localparam int NUM_INSTR      = 400;
    localparam int INIT_CYCLES    = `ISSUE_NUM_REGS;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 8 + INIT_CYCLES;
    // x0 to x7 only so hazards come often
    localparam int POOL           = 8;

    // error kinds
    localparam int E_INIT   = 0;
    localparam int E_HAZARD = 1;
    localparam int E_TIMING = 2;
    localparam int E_DATA   = 3;
    localparam int E_ORDER  = 4;

    logic         clk;
    logic         rst;
    logic         in_valid;
    isa_pkg::op_e in_op;
    reg_addr_t    in_rd;
    reg_addr_t    in_rs1;
    reg_addr_t    in_rs2;
    word_t        in_imm;
    logic         in_ready;
    logic         wb_valid;
    reg_addr_t    wb_rd;
    word_t        wb_data;

    // reference model state
    word_t     model_regs [`ISSUE_NUM_REGS];
    reg_addr_t pend_rd  [$];
    word_t     pend_val [$];
    int        pend_due [$];

    int err_cnt [5];
    int cyc;
    int sent;
    int accepted_count;
    bit hold;
    int cycle_count = 0;

    tb_clock tb_clock_i (
        .clk (clk),
        .rst (rst)
    );

    issue_core issue_core_i (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_op    (in_op),
        .in_rd    (in_rd),
        .in_rs1   (in_rs1),
        .in_rs2   (in_rs2),
        .in_imm   (in_imm),
        .in_ready (in_ready),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    ////////////////////////////////////////
    // reference model

    // result of one instruction with mul keeping the low word
    function automatic word_t compute_result(
        input isa_pkg::op_e op,
        input word_t        a,
        input word_t        b,
        input word_t        imm
    );
        logic [2*`ISSUE_XLEN-1:0] product;
        product = {{`ISSUE_XLEN{1'b0}}, a} * {{`ISSUE_XLEN{1'b0}}, b};
        case (op)
            isa_pkg::OP_ADD:  return a + b;
            isa_pkg::OP_SUB:  return a - b;
            isa_pkg::OP_XOR:  return a ^ b;
            isa_pkg::OP_ADDI: return a + imm;
            isa_pkg::OP_MUL:  return product[`ISSUE_XLEN-1:0];
            default:          return '0;
        endcase
    endfunction

    function automatic bit is_pending(input reg_addr_t r);
        for (int i = 0; i < pend_rd.size(); i++) begin
            if (pend_rd[i] == r) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic int total_errors();
        return err_cnt[0] + err_cnt[1] + err_cnt[2] + err_cnt[3] + err_cnt[4];
    endfunction

    task automatic log_error(input int kind, input string msg);
        err_cnt[kind]++;
        $display("** Error at %0t: %s", $time, msg);
    endtask

    task automatic print_summary();
        $display("errors: init %0d, hazard %0d, timing %0d, data %0d, order %0d",
                 err_cnt[E_INIT], err_cnt[E_HAZARD], err_cnt[E_TIMING],
                 err_cnt[E_DATA], err_cnt[E_ORDER]);
    endtask

    ////////////////////////////////////////
    // per-cycle checks sampled at the falling edge

    task automatic check_init();
        if (cyc < INIT_CYCLES) begin
            assert (!in_ready) else log_error(E_INIT, "in_ready high during init");
        end
        if (cyc == INIT_CYCLES) begin
            assert (in_ready) else log_error(E_INIT, "in_ready still low after init");
        end
    endtask

    // operands and rd must have no result outstanding
    task automatic check_hazards();
        if (in_valid && in_ready) begin
            assert (in_rs1 == '0 || !is_pending(in_rs1))
                else log_error(E_HAZARD, $sformatf("accepted with x%0d pending", in_rs1));
            assert (in_rs2 == '0 || in_op == isa_pkg::OP_ADDI || !is_pending(in_rs2))
                else log_error(E_HAZARD, $sformatf("accepted with x%0d pending", in_rs2));
            assert (in_rd == '0 || !is_pending(in_rd))
                else log_error(E_HAZARD, $sformatf("accepted with rd x%0d pending", in_rd));
        end
    endtask

    task automatic check_writeback();
        int found;
        int i;
        bit missed;
        if (wb_valid) begin
            found = -1;
            // oldest entry for this rd
            for (i = 0; i < pend_rd.size(); i++) begin
                if (found < 0 && pend_rd[i] == wb_rd) begin
                    found = i;
                end
            end
            assert (accepted_count > 0)
                else log_error(E_INIT, "writeback before the first acceptance");
            assert (wb_rd != '0) else log_error(E_ORDER, "writeback to x0");
            assert (found >= 0)
                else log_error(E_ORDER, $sformatf("unexpected writeback to x%0d", wb_rd));
            if (found >= 0) begin
                assert (pend_due[found] == cyc)
                    else log_error(E_TIMING, $sformatf("x%0d written in cycle %0d, expected %0d",
                                                       wb_rd, cyc, pend_due[found]));
                assert (wb_data == pend_val[found])
                    else log_error(E_DATA, $sformatf("x%0d got %h, expected %h",
                                                     wb_rd, wb_data, pend_val[found]));
                pend_rd.delete(found);
                pend_val.delete(found);
                pend_due.delete(found);
            end
        end
        // anything due by now and still queued never came back
        i = 0;
        while (i < pend_rd.size()) begin
            missed = (pend_due[i] <= cyc);
            assert (!missed)
                else log_error(E_TIMING, $sformatf("no writeback for x%0d in cycle %0d",
                                                   pend_rd[i], pend_due[i]));
            if (missed) begin
                pend_rd.delete(i);
                pend_val.delete(i);
                pend_due.delete(i);
            end else begin
                i++;
            end
        end
    endtask

    // executes in program order with results due 1 or MUL_STAGES cycles later
    task automatic accept_instruction();
        word_t value;
        if (in_valid && in_ready) begin
            value = compute_result(in_op, model_regs[in_rs1], model_regs[in_rs2], in_imm);
            if (in_rd != '0) begin
                model_regs[in_rd] = value;
                pend_rd.push_back(in_rd);
                pend_val.push_back(value);
                if (in_op == isa_pkg::OP_MUL) begin
                    pend_due.push_back(cyc + `ISSUE_MUL_STAGES);
                end else begin
                    pend_due.push_back(cyc + 1);
                end
            end
            accepted_count++;
            hold = 1'b0;
        end
    endtask

    ////////////////////////////////////////
    // stimulus

    // held instruction stays put until accepted
    task automatic drive_next();
        if (!hold) begin
            if (sent < POOL - 1) begin
                // load every pool register from x0 first
                in_op  = isa_pkg::OP_ADDI;
                in_rd  = reg_addr_t'(sent + 1);
                in_rs1 = '0;
                in_rs2 = '0;
                in_imm = $urandom;
                in_valid = 1'b1;
                hold = 1'b1;
                sent++;
            end else if (sent < NUM_INSTR && ($urandom % 8) != 0) begin
                in_op  = isa_pkg::op_e'(3'($urandom % 5));
                in_rd  = reg_addr_t'($urandom % POOL);
                in_rs1 = reg_addr_t'($urandom % POOL);
                in_rs2 = reg_addr_t'($urandom % POOL);
                in_imm = $urandom;
                in_valid = 1'b1;
                hold = 1'b1;
                sent++;
            end else begin
                in_valid = 1'b0;
            end
        end
    endtask

    initial begin
        in_valid = 1'b0;
        in_op    = isa_pkg::OP_ADD;
        in_rd    = '0;
        in_rs1   = '0;
        in_rs2   = '0;
        in_imm   = '0;
        for (int r = 0; r < `ISSUE_NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        for (int k = 0; k < 5; k++) begin
            err_cnt[k] = 0;
        end
        void'($urandom(SEED));
        cyc            = 0;
        sent           = 0;
        accepted_count = 0;
        hold           = 1'b0;

        @(negedge clk);
        while (rst) @(negedge clk);

        // cycle 0 is the first init cycle
        while (!(sent == NUM_INSTR && !hold && pend_rd.size() == 0)) begin
            check_init();
            check_hazards();
            check_writeback();
            accept_instruction();
            @(posedge clk);
            #1;
            drive_next();
            @(negedge clk);
            cyc++;
        end

        // once drained nothing more may come back
        repeat (4) begin
            assert (!wb_valid)
                else log_error(E_ORDER, $sformatf("extra writeback to x%0d", wb_rd));
            @(negedge clk);
        end

        print_summary();
        if (total_errors() == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    ////////////////////////////////////////
    // timeout

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish in %0d cycles, %0d results outstanding",
                     TIMEOUT_CYCLES, pend_rd.size());
            print_summary();
            $display("** FAIL **");
            $finish;
        end
    end

endmodule

`default_nettype wire
